/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_pattern_memory
RTL_TOP    ?= pattern_memory
FILELIST   ?= compile.f
FLAGS      ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+testbench
logic/bus_pkg.sv
logic/mem_pkg.sv
logic/host_ctrl.sv
logic/seg_mem.sv
logic/pattern_memory.sv
testbench/tb_pattern_memory.sv

/* logic/bus_pkg.sv */
package bus_pkg;

  // Host bus geometry
  localparam int HOST_AW = 17;
  localparam int HOST_DW = 16;
  localparam int RESP_W  = 2;

  // Bank select codes, top two bits of the word index
  localparam logic [1:0] SEL_CTL    = 2'd0;
  localparam logic [1:0] SEL_NORMAL = 2'd1;
  localparam logic [1:0] SEL_MOD    = 2'd2;
  localparam logic [1:0] SEL_STM    = 2'd3;

  // Control register indices
  localparam logic [7:0] REG_MOD_WR_SEGMENT = 8'd0;
  localparam logic [7:0] REG_STM_WR_SEGMENT = 8'd1;
  localparam logic [7:0] REG_STM_WR_PAGE    = 8'd2;
  localparam logic [7:0] REG_VERSION        = 8'd3;

  localparam logic [15:0] CTL_VERSION = 16'h0a31;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Host word index, byte address shifted right by one
  // Memory banks use the wide offset, the control bank an 8-bit index
  typedef union packed {
    struct packed {
      logic [1:0]  sel;
      logic [13:0] offset;
    } mem;
    struct packed {
      logic [1:0] sel;
      logic [5:0] rsvd;
      logic [7:0] idx;
    } ctl;
  } host_addr_t;

endpackage

/* logic/host_ctrl.sv */
`timescale 1ns/1ps

module host_ctrl import bus_pkg::*; #(
  parameter int NORMAL_WR_AW = 8,
  parameter int MOD_WR_AW    = 10,
  parameter int STM_WR_AW    = 12,
  parameter int STM_PAGE_W   = 2
) (
  input  logic                    bus_clk,
  input  logic                    rst,

  // AXI4-Lite write channels
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [HOST_AW-1:0]      awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  logic [HOST_DW-1:0]      wdata,
  output logic                    bvalid,
  input  logic                    bready,
  output logic [RESP_W-1:0]       bresp,

  // AXI4-Lite read channels
  input  logic                    arvalid,
  output logic                    arready,
  input  logic [HOST_AW-1:0]      araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output logic [HOST_DW-1:0]      rdata,
  output logic [RESP_W-1:0]       rresp,

  // Bank write ports
  output logic                    normal_we,
  output logic                    normal_wr_seg,
  output logic [NORMAL_WR_AW-1:0] normal_wr_addr,
  output logic                    mod_we,
  output logic                    mod_wr_seg,
  output logic [MOD_WR_AW-1:0]    mod_wr_addr,
  output logic                    stm_we,
  output logic                    stm_wr_seg,
  output logic [STM_WR_AW-1:0]    stm_wr_addr,
  output logic [HOST_DW-1:0]      wr_data
);

  localparam int STM_OFS_W = STM_WR_AW - STM_PAGE_W;

  host_addr_t waddr;
  host_addr_t raddr;

  logic wr_acc;
  logic rd_acc;

  logic                  mod_seg_q;
  logic                  stm_seg_q;
  logic [STM_PAGE_W-1:0] stm_page_q;

  logic [HOST_DW-1:0] rd_word;
  logic [RESP_W-1:0]  rd_resp;

  // Drop the byte bit, the bus is word addressed
  assign waddr = awaddr[HOST_AW-1:1];
  assign raddr = araddr[HOST_AW-1:1];

  // Address and data taken together, stalled while a response waits
  assign wr_acc  = awvalid & wvalid & ~bvalid;
  assign awready = wr_acc;
  assign wready  = wr_acc;

  assign rd_acc = arvalid & arready;

  // Write response, bank strobes and control registers
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      bvalid     <= 1'b0;
      bresp      <= RESP_OKAY;
      normal_we  <= 1'b0;
      mod_we     <= 1'b0;
      stm_we     <= 1'b0;
      mod_seg_q  <= 1'b0;
      stm_seg_q  <= 1'b0;
      stm_page_q <= '0;
    end else begin
      normal_we <= 1'b0;
      mod_we    <= 1'b0;
      stm_we    <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_acc) begin
        bvalid <= 1'b1;
        bresp  <= RESP_OKAY;
        case (waddr.mem.sel)
          SEL_NORMAL: normal_we <= 1'b1;
          SEL_MOD:    mod_we <= 1'b1;
          SEL_STM:    stm_we <= 1'b1;
          default: begin
            // Control bank, decoded by register index
            case (waddr.ctl.idx)
              REG_MOD_WR_SEGMENT: mod_seg_q <= wdata[0];
              REG_STM_WR_SEGMENT: stm_seg_q <= wdata[0];
              REG_STM_WR_PAGE:    stm_page_q <= wdata[STM_PAGE_W-1:0];
              // Version is read only, anything else is unmapped
              default:            bresp <= RESP_SLVERR;
            endcase
          end
        endcase
      end
    end
  end

  // Write address and data, qualified by the strobes one cycle later
  always_ff @(posedge bus_clk) begin
    if (wr_acc) begin
      wr_data        <= wdata;
      normal_wr_seg  <= waddr.mem.offset[NORMAL_WR_AW];
      normal_wr_addr <= waddr.mem.offset[NORMAL_WR_AW-1:0];
      mod_wr_seg     <= mod_seg_q;
      mod_wr_addr    <= waddr.mem.offset[MOD_WR_AW-1:0];
      stm_wr_seg     <= stm_seg_q;
      // Page register selects the upper part of the STM address
      stm_wr_addr    <= {stm_page_q, waddr.mem.offset[STM_OFS_W-1:0]};
    end
  end

  // Register readback, memory windows are write only
  always_comb begin
    rd_word = '0;
    rd_resp = RESP_SLVERR;
    if (raddr.ctl.sel == SEL_CTL) begin
      rd_resp = RESP_OKAY;
      case (raddr.ctl.idx)
        REG_MOD_WR_SEGMENT: rd_word = HOST_DW'(mod_seg_q);
        REG_STM_WR_SEGMENT: rd_word = HOST_DW'(stm_seg_q);
        REG_STM_WR_PAGE:    rd_word = HOST_DW'(stm_page_q);
        REG_VERSION:        rd_word = CTL_VERSION;
        default:            rd_resp = RESP_SLVERR;
      endcase
    end
  end

  // Read handshake, one outstanding read at a time
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else if (rd_acc) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
    end else if (rvalid && rready) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end else if (!rvalid) begin
      arready <= 1'b1;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rd_acc) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

  // Every memory is written one 16-bit word at a time
  localparam int WR_W = 16;

  // Normal phase/intensity memory
  localparam int NORMAL_WR_AW   = 8;
  localparam int NORMAL_RD_W    = 16;
  localparam int NORMAL_RD_AW   = NORMAL_WR_AW + $clog2(WR_W) - $clog2(NORMAL_RD_W);
  localparam int NORMAL_SEG_BIT = 8;

  // Modulation waveform, read back byte by byte
  localparam int MOD_WR_AW = 10;
  localparam int MOD_RD_W  = 8;
  localparam int MOD_RD_AW = MOD_WR_AW + $clog2(WR_W) - $clog2(MOD_RD_W);

  // STM focus memory, four words per read
  localparam int STM_WR_AW  = 12;
  localparam int STM_RD_W   = 64;
  localparam int STM_RD_AW  = STM_WR_AW + $clog2(WR_W) - $clog2(STM_RD_W);
  localparam int STM_PAGE_W = 2;

endpackage

/* logic/pattern_memory.sv */
`timescale 1ns/1ps

module pattern_memory import bus_pkg::*, mem_pkg::*; (
  input  logic                    bus_clk,
  input  logic                    rst,

  // Host AXI4-Lite slave
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [HOST_AW-1:0]      awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  logic [HOST_DW-1:0]      wdata,
  output logic                    bvalid,
  input  logic                    bready,
  output logic [RESP_W-1:0]       bresp,
  input  logic                    arvalid,
  output logic                    arready,
  input  logic [HOST_AW-1:0]      araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output logic [HOST_DW-1:0]      rdata,
  output logic [RESP_W-1:0]       rresp,

  // Array side read ports
  input  logic [NORMAL_RD_AW-1:0] normal_idx,
  input  logic                    normal_seg,
  output logic [NORMAL_RD_W-1:0]  normal_value,
  input  logic [MOD_RD_AW-1:0]    mod_idx,
  input  logic                    mod_seg,
  output logic [MOD_RD_W-1:0]     mod_value,
  input  logic [STM_RD_AW-1:0]    stm_idx,
  input  logic                    stm_seg,
  output logic [STM_RD_W-1:0]     stm_value
);

  logic                    normal_we;
  logic                    normal_wr_seg;
  logic [NORMAL_WR_AW-1:0] normal_wr_addr;
  logic                    mod_we;
  logic                    mod_wr_seg;
  logic [MOD_WR_AW-1:0]    mod_wr_addr;
  logic                    stm_we;
  logic                    stm_wr_seg;
  logic [STM_WR_AW-1:0]    stm_wr_addr;
  logic [WR_W-1:0]         wr_data;

  host_ctrl #(
    .NORMAL_WR_AW (NORMAL_WR_AW),
    .MOD_WR_AW    (MOD_WR_AW),
    .STM_WR_AW    (STM_WR_AW),
    .STM_PAGE_W   (STM_PAGE_W)
  ) ctrl (
    .bus_clk        (bus_clk),
    .rst            (rst),
    .awvalid        (awvalid),
    .awready        (awready),
    .awaddr         (awaddr),
    .wvalid         (wvalid),
    .wready         (wready),
    .wdata          (wdata),
    .bvalid         (bvalid),
    .bready         (bready),
    .bresp          (bresp),
    .arvalid        (arvalid),
    .arready        (arready),
    .araddr         (araddr),
    .rvalid         (rvalid),
    .rready         (rready),
    .rdata          (rdata),
    .rresp          (rresp),
    .normal_we      (normal_we),
    .normal_wr_seg  (normal_wr_seg),
    .normal_wr_addr (normal_wr_addr),
    .mod_we         (mod_we),
    .mod_wr_seg     (mod_wr_seg),
    .mod_wr_addr    (mod_wr_addr),
    .stm_we         (stm_we),
    .stm_wr_seg     (stm_wr_seg),
    .stm_wr_addr    (stm_wr_addr),
    .wr_data        (wr_data)
  );

  // Phase/intensity words, one per transducer
  seg_mem #(
    .WR_AW (NORMAL_WR_AW),
    .RD_W  (NORMAL_RD_W)
  ) normal_mem (
    .bus_clk  (bus_clk),
    .we       (normal_we),
    .wr_seg   (normal_wr_seg),
    .wr_addr  (normal_wr_addr),
    .wr_data  (wr_data),
    .rd_idx   (normal_idx),
    .rd_seg   (normal_seg),
    .rd_value (normal_value)
  );

  // Modulation samples, two per host word
  seg_mem #(
    .WR_AW (MOD_WR_AW),
    .RD_W  (MOD_RD_W)
  ) mod_mem (
    .bus_clk  (bus_clk),
    .we       (mod_we),
    .wr_seg   (mod_wr_seg),
    .wr_addr  (mod_wr_addr),
    .wr_data  (wr_data),
    .rd_idx   (mod_idx),
    .rd_seg   (mod_seg),
    .rd_value (mod_value)
  );

  // STM focus points, four host words each
  seg_mem #(
    .WR_AW (STM_WR_AW),
    .RD_W  (STM_RD_W)
  ) stm_mem (
    .bus_clk  (bus_clk),
    .we       (stm_we),
    .wr_seg   (stm_wr_seg),
    .wr_addr  (stm_wr_addr),
    .wr_data  (wr_data),
    .rd_idx   (stm_idx),
    .rd_seg   (stm_seg),
    .rd_value (stm_value)
  );

endmodule

/* logic/seg_mem.sv */
`timescale 1ns/1ps

module seg_mem #(
  parameter int  WR_AW = 8,
  parameter int  RD_W  = 16,
  localparam int RD_AW = WR_AW + 4 - $clog2(RD_W)
) (
  input  logic             bus_clk,
  input  logic             we,
  input  logic             wr_seg,
  input  logic [WR_AW-1:0] wr_addr,
  input  logic [15:0]      wr_data,
  input  logic [RD_AW-1:0] rd_idx,
  input  logic             rd_seg,
  output logic [RD_W-1:0]  rd_value
);

  localparam int DEPTH = 2 ** WR_AW;

  // One array per segment, played and rewritten independently
  logic [15:0] seg0 [DEPTH];
  logic [15:0] seg1 [DEPTH];

  always_ff @(posedge bus_clk) begin
    if (we) begin
      if (wr_seg) begin
        seg1[wr_addr] <= wr_data;
      end else begin
        seg0[wr_addr] <= wr_data;
      end
    end
  end

  if (RD_W < 16) begin : g_narrow
    // Several read lanes share one stored word
    localparam int LANE_AW = $clog2(16 / RD_W);

    logic [WR_AW-1:0]   word_addr;
    logic [LANE_AW-1:0] lane;
    logic [15:0]        word;

    assign word_addr = rd_idx[RD_AW-1:LANE_AW];
    assign lane      = rd_idx[LANE_AW-1:0];
    assign word      = rd_seg ? seg1[word_addr] : seg0[word_addr];

    // Low index bit picks the low lane
    always_ff @(posedge bus_clk) begin
      rd_value <= word[lane*RD_W +: RD_W];
    end
  end else begin : g_wide
    // Consecutive words, lowest address in the low bits
    localparam int WORDS = RD_W / 16;

    logic [RD_W-1:0] line;

    always_comb begin
      for (int k = 0; k < WORDS; k++) begin
        line[k*16 +: 16] = rd_seg ? seg1[WR_AW'(rd_idx * WORDS + k)]
                                  : seg0[WR_AW'(rd_idx * WORDS + k)];
      end
    end

    always_ff @(posedge bus_clk) begin
      rd_value <= line;
    end
  end

endmodule

/* testbench/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Row operations
localparam logic [1:0] OP_WRITE = 2'd0;
localparam logic [1:0] OP_READ  = 2'd1;
localparam logic [1:0] OP_ARRAY = 2'd2;
localparam logic [1:0] OP_STALL = 2'd3;

// Bank and offset form the host address or the array index
typedef struct {
  logic [1:0]  op;
  string       name;
  logic [1:0]  bank;
  logic [13:0] ofs;
  logic        seg;
  logic [15:0] data;
  logic [15:0] exp;
  logic [1:0]  resp;
} vec_t;

vec_t vectors[$];

function automatic logic [13:0] reg_ofs(logic [7:0] idx);
  return {6'd0, idx};
endfunction

function automatic void add_row(logic [1:0] op, string name, logic [1:0] bank,
                                logic [13:0] ofs, logic seg, logic [15:0] data,
                                logic [15:0] exp, logic [1:0] resp);
  vec_t v;
  v.op   = op;
  v.name = name;
  v.bank = bank;
  v.ofs  = ofs;
  v.seg  = seg;
  v.data = data;
  v.exp  = exp;
  v.resp = resp;
  vectors.push_back(v);
endfunction

function automatic void add_write(string name, logic [1:0] bank, logic [13:0] ofs,
                                  logic [15:0] data, logic [1:0] resp);
  add_row(OP_WRITE, name, bank, ofs, 1'b0, data, 16'h0000, resp);
endfunction

function automatic void add_read(string name, logic [1:0] bank, logic [13:0] ofs,
                                 logic [15:0] exp, logic [1:0] resp);
  add_row(OP_READ, name, bank, ofs, 1'b0, 16'h0000, exp, resp);
endfunction

// Expected array value comes from the reference model
function automatic void add_array_read(string name, logic [1:0] bank, logic [13:0] idx,
                                       logic seg);
  add_row(OP_ARRAY, name, bank, idx, seg, 16'h0000, 16'h0000, RESP_OKAY);
endfunction

function automatic void load_vectors();
  // Register state out of reset
  add_read("mod segment reset", SEL_CTL, reg_ofs(REG_MOD_WR_SEGMENT), 16'h0000, RESP_OKAY);
  add_read("stm segment reset", SEL_CTL, reg_ofs(REG_STM_WR_SEGMENT), 16'h0000, RESP_OKAY);
  add_read("stm page reset", SEL_CTL, reg_ofs(REG_STM_WR_PAGE), 16'h0000, RESP_OKAY);
  add_read("version", SEL_CTL, reg_ofs(REG_VERSION), CTL_VERSION, RESP_OKAY);
  // Rejected accesses
  add_write("version write", SEL_CTL, reg_ofs(REG_VERSION), 16'h1234, RESP_SLVERR);
  add_read("version kept", SEL_CTL, reg_ofs(REG_VERSION), CTL_VERSION, RESP_OKAY);
  add_write("unmapped write", SEL_CTL, reg_ofs(8'h40), 16'h0001, RESP_SLVERR);
  add_read("unmapped write kept", SEL_CTL, reg_ofs(REG_MOD_WR_SEGMENT), 16'h0000, RESP_OKAY);
  add_read("unmapped read", SEL_CTL, reg_ofs(8'h40), 16'h0000, RESP_SLVERR);
  add_read("normal window read", SEL_NORMAL, 14'h005, 16'h0000, RESP_SLVERR);
  add_read("mod window read", SEL_MOD, 14'h007, 16'h0000, RESP_SLVERR);
  add_read("stm window read", SEL_STM, 14'h00c, 16'h0000, RESP_SLVERR);
  // Offset bit 8 picks the normal segment
  add_write("normal seg0 write", SEL_NORMAL, 14'h005, 16'($urandom), RESP_OKAY);
  add_write("normal seg1 write", SEL_NORMAL, 14'h105, 16'($urandom), RESP_OKAY);
  add_array_read("normal seg0 read", SEL_NORMAL, 14'd5, 1'b0);
  add_array_read("normal seg1 read", SEL_NORMAL, 14'd5, 1'b1);
  // Modulation bytes with segment 0 written first
  add_write("mod seg0 write", SEL_MOD, 14'h007, 16'($urandom), RESP_OKAY);
  add_write("mod segment set", SEL_CTL, reg_ofs(REG_MOD_WR_SEGMENT), 16'hfff3, RESP_OKAY);
  add_read("mod segment masked", SEL_CTL, reg_ofs(REG_MOD_WR_SEGMENT), 16'h0001, RESP_OKAY);
  add_write("mod seg1 write", SEL_MOD, 14'h007, 16'($urandom), RESP_OKAY);
  add_array_read("mod seg1 low byte", SEL_MOD, 14'd14, 1'b1);
  add_array_read("mod seg1 high byte", SEL_MOD, 14'd15, 1'b1);
  add_array_read("mod seg0 low byte", SEL_MOD, 14'd14, 1'b0);
  add_array_read("mod seg0 high byte", SEL_MOD, 14'd15, 1'b0);
  // STM page 2 in segment 0 and page 1 in segment 1
  add_write("stm page set", SEL_CTL, reg_ofs(REG_STM_WR_PAGE), 16'h00fe, RESP_OKAY);
  add_read("stm page masked", SEL_CTL, reg_ofs(REG_STM_WR_PAGE), 16'h0002, RESP_OKAY);
  for (int k = 12; k < 16; k++) begin
    add_write("stm page2 word", SEL_STM, 14'(k), 16'($urandom), RESP_OKAY);
  end
  add_write("stm segment set", SEL_CTL, reg_ofs(REG_STM_WR_SEGMENT), 16'h0001, RESP_OKAY);
  add_read("stm segment read", SEL_CTL, reg_ofs(REG_STM_WR_SEGMENT), 16'h0001, RESP_OKAY);
  add_write("stm page1 set", SEL_CTL, reg_ofs(REG_STM_WR_PAGE), 16'h0001, RESP_OKAY);
  for (int k = 0; k < 4; k++) begin
    add_write("stm page1 word", SEL_STM, 14'(k), 16'($urandom), RESP_OKAY);
  end
  add_array_read("stm page2 line", SEL_STM, 14'd515, 1'b0);
  add_array_read("stm page1 line", SEL_STM, 14'd256, 1'b1);
  // Write held off by a pending response
  add_row(OP_STALL, "normal stalled write", SEL_NORMAL, 14'h033, 1'b0, 16'($urandom),
          16'h0000, RESP_OKAY);
  add_array_read("normal after stall", SEL_NORMAL, 14'h033, 1'b0);
endfunction

`endif

/* testbench/tb_pattern_memory.sv */
`timescale 1ns/1ps

module tb_pattern_memory import bus_pkg::*, mem_pkg::*; ();

  localparam int RESET_CYCLES = 8;
  localparam int HS_LIMIT     = 20;

  logic                    bus_clk = 1'b0;
  logic                    rst;
  logic                    awvalid;
  logic                    awready;
  logic [HOST_AW-1:0]      awaddr;
  logic                    wvalid;
  logic                    wready;
  logic [HOST_DW-1:0]      wdata;
  logic                    bvalid;
  logic                    bready;
  logic [RESP_W-1:0]       bresp;
  logic                    arvalid;
  logic                    arready;
  logic [HOST_AW-1:0]      araddr;
  logic                    rvalid;
  logic                    rready;
  logic [HOST_DW-1:0]      rdata;
  logic [RESP_W-1:0]       rresp;
  logic [NORMAL_RD_AW-1:0] normal_idx;
  logic                    normal_seg;
  logic [NORMAL_RD_W-1:0]  normal_value;
  logic [MOD_RD_AW-1:0]    mod_idx;
  logic                    mod_seg;
  logic [MOD_RD_W-1:0]     mod_value;
  logic [STM_RD_AW-1:0]    stm_idx;
  logic                    stm_seg;
  logic [STM_RD_W-1:0]     stm_value;

  // Reference contents by bank, segment and write address
  logic [15:0] model [32768];
  logic        mod_seg_ref = 1'b0;
  logic        stm_seg_ref = 1'b0;
  logic [1:0]  page_ref = 2'd0;

  int errors = 0;
  int cycles = 0;
  int cycle_limit = 0;

  `include "tb_vectors.svh"

  pattern_memory uut (.*);

  always #2 bus_clk = ~bus_clk;

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the table did not complete", cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [HOST_AW-1:0] host_addr(vec_t v);
    return {v.bank, v.ofs, 1'b0};
  endfunction

  function automatic logic [14:0] model_key(logic [1:0] bank, logic seg, logic [11:0] addr);
    return {bank, seg, addr};
  endfunction

  // Write routing as seen from the host
  function automatic void update_model(vec_t v);
    case (v.bank)
      SEL_NORMAL: begin
        model[model_key(SEL_NORMAL, v.ofs[NORMAL_SEG_BIT], 12'(v.ofs[7:0]))] = v.data;
      end
      SEL_MOD:    model[model_key(SEL_MOD, mod_seg_ref, 12'(v.ofs[9:0]))] = v.data;
      SEL_STM:    model[model_key(SEL_STM, stm_seg_ref, {page_ref, v.ofs[9:0]})] = v.data;
      default: begin
        if (v.ofs == reg_ofs(REG_MOD_WR_SEGMENT)) begin
          mod_seg_ref = v.data[0];
        end else if (v.ofs == reg_ofs(REG_STM_WR_SEGMENT)) begin
          stm_seg_ref = v.data[0];
        end else if (v.ofs == reg_ofs(REG_STM_WR_PAGE)) begin
          page_ref = v.data[1:0];
        end
      end
    endcase
  endfunction

  function automatic logic [63:0] array_expect(vec_t v);
    logic [15:0] w;
    logic [63:0] words;
    words = '0;
    case (v.bank)
      SEL_NORMAL: return 64'(model[model_key(SEL_NORMAL, v.seg, 12'(v.ofs[7:0]))]);
      SEL_MOD: begin
        // Odd index is the high byte
        w = model[model_key(SEL_MOD, v.seg, 12'(v.ofs[10:1]))];
        return v.ofs[0] ? 64'(w[15:8]) : 64'(w[7:0]);
      end
      default: begin
        for (int k = 0; k < 4; k++) begin
          words[k*16 +: 16] = model[model_key(SEL_STM, v.seg, 12'(v.ofs * 4 + k))];
        end
        return words;
      end
    endcase
  endfunction

  task automatic present_write(input logic [HOST_AW-1:0] addr, input logic [15:0] data);
    int waited;
    waited = 0;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= data;
    do begin
      @(posedge bus_clk);
      waited++;
    end while (!(awready && wready) && waited < HS_LIMIT);
    if (!(awready && wready)) begin
      $display("write to %h was never accepted", addr);
      errors++;
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  task automatic wait_response(output logic [1:0] resp);
    int waited;
    waited = 0;
    do begin
      @(posedge bus_clk);
      waited++;
    end while (!(bvalid && bready) && waited < HS_LIMIT);
    if (!(bvalid && bready)) begin
      $display("no write response arrived");
      errors++;
    end
    resp = bresp;
  endtask

  task automatic axi_read(input logic [HOST_AW-1:0] addr, output logic [15:0] data,
                          output logic [1:0] resp);
    int waited;
    waited = 0;
    arvalid <= 1'b1;
    araddr  <= addr;
    do begin
      @(posedge bus_clk);
      waited++;
    end while (!arready && waited < HS_LIMIT);
    if (!arready) begin
      $display("read of %h was never accepted", addr);
      errors++;
    end
    arvalid <= 1'b0;
    waited = 0;
    do begin
      @(posedge bus_clk);
      waited++;
    end while (!(rvalid && rready) && waited < HS_LIMIT);
    if (!(rvalid && rready)) begin
      $display("no read response arrived for %h", addr);
      errors++;
    end
    data = rdata;
    resp = rresp;
  endtask

  // Value is registered one edge after the index and sampled mid-cycle
  task automatic array_read(input vec_t v, output logic [63:0] value);
    case (v.bank)
      SEL_NORMAL: begin
        normal_idx <= v.ofs[NORMAL_RD_AW-1:0];
        normal_seg <= v.seg;
      end
      SEL_MOD: begin
        mod_idx <= v.ofs[MOD_RD_AW-1:0];
        mod_seg <= v.seg;
      end
      default: begin
        stm_idx <= v.ofs[STM_RD_AW-1:0];
        stm_seg <= v.seg;
      end
    endcase
    @(posedge bus_clk);
    @(negedge bus_clk);
    case (v.bank)
      SEL_NORMAL: value = 64'(normal_value);
      SEL_MOD:    value = 64'(mod_value);
      default:    value = stm_value;
    endcase
  endtask

  // First write holds its response while a second one waits behind it
  task automatic stalled_write(input vec_t v, output logic [1:0] resp);
    bready <= 1'b0;
    present_write(host_addr(v), ~v.data);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= host_addr(v);
    wdata   <= v.data;
    repeat (4) begin
      @(posedge bus_clk);
      if (!bvalid) begin
        $display("%s: bvalid dropped while bready was low", v.name);
        errors++;
      end
      if (awready || wready) begin
        $display("%s: second write accepted while a response was pending", v.name);
        errors++;
      end
    end
    bready <= 1'b1;
    wait_response(resp);
    if (resp !== RESP_OKAY) begin
      $display("[ERROR] %s: expected resp %h, actual %h", v.name, RESP_OKAY, resp);
      errors++;
    end
    present_write(host_addr(v), v.data);
    wait_response(resp);
  endtask

  initial begin
    vec_t        v;
    logic [1:0]  resp;
    logic [15:0] word;
    logic [63:0] value;
    logic [63:0] expected;
    void'($urandom(32'hb180_a5c3));
    rst        <= 1'b1;
    awvalid    <= 1'b0;
    awaddr     <= '0;
    wvalid     <= 1'b0;
    wdata      <= '0;
    bready     <= 1'b1;
    arvalid    <= 1'b0;
    araddr     <= '0;
    rready     <= 1'b1;
    normal_idx <= '0;
    normal_seg <= 1'b0;
    mod_idx    <= '0;
    mod_seg    <= 1'b0;
    stm_idx    <= '0;
    stm_seg    <= 1'b0;
    load_vectors();
    cycle_limit = 40 * vectors.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    rst <= 1'b0;

    foreach (vectors[i]) begin
      v = vectors[i];
      @(posedge bus_clk);
      case (v.op)
        OP_WRITE: begin
          present_write(host_addr(v), v.data);
          wait_response(resp);
          if (resp !== v.resp) begin
            $display("[ERROR] %s: expected resp %h, actual %h", v.name, v.resp, resp);
            errors++;
          end
          update_model(v);
        end
        OP_READ: begin
          axi_read(host_addr(v), word, resp);
          if (word !== v.exp) begin
            $display("[ERROR] %s: expected %h, actual %h", v.name, v.exp, word);
            errors++;
          end
          if (resp !== v.resp) begin
            $display("[ERROR] %s: expected resp %h, actual %h", v.name, v.resp, resp);
            errors++;
          end
        end
        OP_ARRAY: begin
          array_read(v, value);
          expected = array_expect(v);
          if (value !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", v.name, expected, value);
            errors++;
          end
        end
        default: begin
          stalled_write(v, resp);
          if (resp !== v.resp) begin
            $display("[ERROR] %s: expected resp %h, actual %h", v.name, v.resp, resp);
            errors++;
          end
          update_model(v);
        end
      endcase
    end

    $display("%0d rows applied, %0d errors", vectors.size(), errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
